//--- console_settings.svh
`ifndef CONSOLE_SETTINGS_SVH
`define CONSOLE_SETTINGS_SVH

// serial line timing
// clock cycles spent on each bit of the 8N1 frame
`define CONSOLE_CLKS_PER_BIT 8

// bit-time counter runs 0 .. CLKS_PER_BIT-1
// width fits the default of 8 cycles per bit
`define CONSOLE_BIT_COUNT_W 3

// frame of start + 8 data + stop bits
`define CONSOLE_FRAME_BITS 10

`endif

//--- consoleTextPkg.sv
`default_nettype none

package consoleTextPkg;

    // one printable or control character
    typedef logic [7:0] asciiChar_t;

    // fixed messages known to the printer
    typedef enum logic [1:0] {
        MSG_INTRO  = 2'd0,
        MSG_PROMPT = 2'd1,
        MSG_CALC   = 2'd2
    } msgId_t;

    // special keys
    localparam asciiChar_t KEY_ENTER    = 8'h0D;
    localparam asciiChar_t KEY_LINEFEED = 8'h0A;

    // option letter that opens the calculator
    localparam asciiChar_t KEY_MODE_CALC = "a";

endpackage

`default_nettype wire

//--- calcPkg.sv
`default_nettype none

package calcPkg;

    // one operator per operator key
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_MUL = 2'd3
    } calcOp_t;

    // single decimal digit 0 to 9
    typedef logic [3:0] digit_t;

    // result wraps to 8 bits when subtraction goes below zero
    function automatic logic [7:0] applyOp(digit_t a, digit_t b, calcOp_t op);
        logic [7:0] wideA;
        logic [7:0] wideB;
        wideA = {4'd0, a};
        wideB = {4'd0, b};
        case (op)
            OP_ADD:  return wideA + wideB;
            OP_SUB:  return wideA - wideB;
            OP_XOR:  return wideA ^ wideB;
            default: return wideA * wideB;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- messagePrinter.sv
`default_nettype none

module messagePrinter import consoleTextPkg::*; (
    input  logic       CLK,
    input  logic       reset,
    input  logic       msgStart,
    input  msgId_t     msgId,
    input  logic       txReady,
    output logic       textSend,
    output asciiChar_t textChar,
    output logic       msgDone
);

    // each text padded to 16 characters with the first character in the top byte
    localparam logic [127:0] INTRO_TEXT  = {"CALC READY", KEY_ENTER, KEY_LINEFEED, 32'h0};
    localparam logic [127:0] PROMPT_TEXT = {"MODE?", KEY_ENTER, KEY_LINEFEED, 72'h0};
    localparam logic [127:0] CALC_TEXT   = {"ALU:", KEY_ENTER, KEY_LINEFEED, 80'h0};

    localparam logic [3:0] INTRO_LEN  = 4'd12;
    localparam logic [3:0] PROMPT_LEN = 4'd7;
    localparam logic [3:0] CALC_LEN   = 4'd6;

    logic       busy;
    msgId_t     curId;
    logic [3:0] index;
    logic [3:0] curLen;

    function automatic asciiChar_t pickChar(logic [127:0] text, logic [3:0] idx);
        return text[7'd127 - {idx, 3'b000} -: 8];
    endfunction

    always_comb begin
        case (curId)
            MSG_INTRO: begin
                curLen   = INTRO_LEN;
                textChar = pickChar(INTRO_TEXT, index);
            end
            MSG_PROMPT: begin
                curLen   = PROMPT_LEN;
                textChar = pickChar(PROMPT_TEXT, index);
            end
            default: begin
                curLen   = CALC_LEN;
                textChar = pickChar(CALC_TEXT, index);
            end
        endcase
    end

    // txReady high means the previous character has left the line
    assign textSend = busy && txReady && (index != curLen);
    assign msgDone  = busy && (index == curLen);

    always_ff @(posedge CLK) begin
        if (reset) begin
            busy  <= 1'b0;
            curId <= MSG_INTRO;
            index <= 4'd0;
        end else if (msgStart) begin
            busy  <= 1'b1;
            curId <= msgId;
            index <= 4'd0;
        end else if (msgDone) begin
            busy <= 1'b0;
        end else if (textSend) begin
            index <= index + 4'd1;
        end
    end

endmodule

`default_nettype wire

//--- keyHandler.sv
`default_nettype none

module keyHandler import consoleTextPkg::*, calcPkg::*; (
    input  logic       CLK,
    input  logic       reset,
    input  logic       keyValid,
    input  asciiChar_t keyData,
    input  logic       txReady,
    input  logic       msgDone,
    output logic       msgStart,
    output msgId_t     msgId,
    output logic       echoSend,
    output asciiChar_t echoChar
);

    localparam asciiChar_t CHAR_ZERO = "0";

    typedef enum logic [2:0] {
        ST_BOOT,
        ST_MSG,
        ST_MODE,
        ST_DIG1,
        ST_OP,
        ST_DIG2,
        ST_ENTER,
        ST_LF
    } handlerState_t;

    handlerState_t state;
    asciiChar_t    option;
    digit_t        digA;
    digit_t        digB;
    calcOp_t       op;

    logic       keyTake;
    logic       keyIsDigit;
    logic       keyIsOp;
    digit_t     keyDigit;
    calcOp_t    keyOp;
    asciiChar_t resultChar;

    // a key counts only while the line is free
    assign keyTake    = keyValid && txReady;
    assign keyIsDigit = (keyData >= "0") && (keyData <= "9");
    // low nibble of an ASCII digit is its value
    assign keyDigit   = keyData[3:0];
    assign resultChar = CHAR_ZERO + applyOp(digA, digB, op);

    always_comb begin
        keyIsOp = 1'b1;
        keyOp   = OP_ADD;
        case (keyData)
            "+":     keyOp = OP_ADD;
            "-":     keyOp = OP_SUB;
            "^":     keyOp = OP_XOR;
            "*":     keyOp = OP_MUL;
            default: keyIsOp = 1'b0;
        endcase
    end

    // echo goes out in the cycle the key arrives
    always_comb begin
        echoSend = 1'b0;
        echoChar = keyData;
        case (state)
            ST_MODE: begin
                echoSend = keyTake;
            end
            ST_DIG1, ST_DIG2: begin
                echoSend = keyTake && keyIsDigit;
            end
            ST_OP: begin
                echoSend = keyTake && keyIsOp;
            end
            ST_ENTER: begin
                // the result character takes the place of the Enter echo
                echoSend = keyTake && (keyData == KEY_ENTER);
                echoChar = resultChar;
            end
            ST_LF: begin
                echoSend = txReady;
                echoChar = KEY_LINEFEED;
            end
            default: begin
                echoSend = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state    <= ST_BOOT;
            msgStart <= 1'b0;
            msgId    <= MSG_INTRO;
            option   <= 8'h00;
            digA     <= 4'd0;
            digB     <= 4'd0;
            op       <= OP_ADD;
        end else begin
            msgStart <= 1'b0;
            case (state)
                ST_BOOT: begin
                    msgStart <= 1'b1;
                    msgId    <= MSG_INTRO;
                    state    <= ST_MSG;
                end
                ST_MSG: begin
                    // msgId still names the message that just finished
                    if (msgDone) begin
                        case (msgId)
                            MSG_INTRO: begin
                                msgStart <= 1'b1;
                                msgId    <= MSG_PROMPT;
                            end
                            MSG_PROMPT: state <= ST_MODE;
                            default:    state <= ST_DIG1;
                        endcase
                    end
                end
                ST_MODE: begin
                    if (echoSend) begin
                        if (keyData == KEY_ENTER) begin
                            msgStart <= 1'b1;
                            state    <= ST_MSG;
                            option   <= 8'h00;
                            if (option == KEY_MODE_CALC) begin
                                msgId <= MSG_CALC;
                            end else begin
                                msgId <= MSG_PROMPT;
                            end
                        end else begin
                            option <= keyData;
                        end
                    end
                end
                ST_DIG1: begin
                    if (echoSend) begin
                        digA  <= keyDigit;
                        state <= ST_OP;
                    end
                end
                ST_OP: begin
                    if (echoSend) begin
                        op    <= keyOp;
                        state <= ST_DIG2;
                    end
                end
                ST_DIG2: begin
                    if (echoSend) begin
                        digB  <= keyDigit;
                        state <= ST_ENTER;
                    end
                end
                ST_ENTER: begin
                    if (echoSend) begin
                        state <= ST_LF;
                    end
                end
                ST_LF: begin
                    if (echoSend) begin
                        msgStart <= 1'b1;
                        msgId    <= MSG_PROMPT;
                        state    <= ST_MSG;
                    end
                end
                default: state <= ST_BOOT;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- consoleTx.sv
`default_nettype none

`include "console_settings.svh"

module consoleTx import consoleTextPkg::*; (
    input  logic       CLK,
    input  logic       reset,
    input  logic       textSend,
    input  asciiChar_t textChar,
    input  logic       echoSend,
    input  asciiChar_t echoChar,
    output logic       txReady,
    output logic       txd
);

    localparam int BIT_W = `CONSOLE_BIT_COUNT_W;
    localparam logic [BIT_W-1:0] LAST_CLK = BIT_W'(`CONSOLE_CLKS_PER_BIT - 1);
    localparam logic [3:0] LAST_BIT = 4'(`CONSOLE_FRAME_BITS - 1);

    logic             busy;
    logic             gap;
    logic [9:0]       frame;
    logic [3:0]       bitIndex;
    logic [BIT_W-1:0] clkCount;

    logic       sendNow;
    asciiChar_t sendChar;

    // the two sources never send in the same cycle
    assign sendNow  = textSend | echoSend;
    assign sendChar = (textChar & {8{textSend}}) | (echoChar & {8{echoSend}});

    assign txReady = ~busy;
    assign txd     = frame[0];

    always_ff @(posedge CLK) begin
        if (reset) begin
            busy     <= 1'b0;
            gap      <= 1'b0;
            frame    <= '1;
            bitIndex <= 4'd0;
            clkCount <= '0;
        end else if (!busy) begin
            if (sendNow) begin
                // stop, data LSB first, start
                frame    <= {1'b1, sendChar, 1'b0};
                busy     <= 1'b1;
                bitIndex <= 4'd0;
                clkCount <= '0;
            end
        end else if (gap) begin
            // one idle cycle after the stop bit
            busy <= 1'b0;
            gap  <= 1'b0;
        end else if (clkCount == LAST_CLK) begin
            clkCount <= '0;
            frame    <= {1'b1, frame[9:1]};
            if (bitIndex == LAST_BIT) begin
                gap <= 1'b1;
            end else begin
                bitIndex <= bitIndex + 4'd1;
            end
        end else begin
            clkCount <= clkCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- consoleTop.sv
`default_nettype none

module consoleTop import consoleTextPkg::*; (
    input  logic       CLK,
    input  logic       reset,
    input  logic       keyValid,
    input  asciiChar_t keyData,
    output logic       txd
);

    logic       msgStart;
    msgId_t     msgId;
    logic       msgDone;
    logic       textSend;
    asciiChar_t textChar;
    logic       echoSend;
    asciiChar_t echoChar;
    logic       txReady;

    messagePrinter printer (
        .CLK      (CLK),
        .reset    (reset),
        .msgStart (msgStart),
        .msgId    (msgId),
        .txReady  (txReady),
        .textSend (textSend),
        .textChar (textChar),
        .msgDone  (msgDone)
    );

    keyHandler handler (
        .CLK      (CLK),
        .reset    (reset),
        .keyValid (keyValid),
        .keyData  (keyData),
        .txReady  (txReady),
        .msgDone  (msgDone),
        .msgStart (msgStart),
        .msgId    (msgId),
        .echoSend (echoSend),
        .echoChar (echoChar)
    );

    // both character sources meet at the transmitter
    consoleTx tx (
        .CLK      (CLK),
        .reset    (reset),
        .textSend (textSend),
        .textChar (textChar),
        .echoSend (echoSend),
        .echoChar (echoChar),
        .txReady  (txReady),
        .txd      (txd)
    );

endmodule

`default_nettype wire

//--- tb_consoleTasks.svh
`ifndef TB_CONSOLE_TASKS_SVH
`define TB_CONSOLE_TASKS_SVH

typedef asciiChar_t charQueue_t[$];

// text followed by CR LF as the console ends a line
function automatic charQueue_t lineText(input string s);
    charQueue_t q;
    int i;
    for (i = 0; i < s.len(); i++) begin
        q.push_back(asciiChar_t'(s[i]));
    end
    q.push_back(KEY_ENTER);
    q.push_back(KEY_LINEFEED);
    return q;
endfunction

// one-cycle key strobe driven just after the rising edge
task automatic sendKey(input asciiChar_t key);
    @(posedge CLK);
    #2;
    keyValid = 1'b1;
    keyData  = key;
    @(posedge CLK);
    #2;
    keyValid = 1'b0;
    keyData  = 8'h00;
endtask

// 8N1 decoder sampling on falling edges near mid-bit
task automatic receiveChar(output asciiChar_t ch);
    int  waited;
    bit  seen;
    int  i;
    ch     = 8'h00;
    waited = 0;
    seen   = 1'b0;
    while (!lineDead && !seen && waited < START_TIMEOUT) begin
        @(negedge CLK);
        if (txd === 1'b0) begin
            seen = 1'b1;
        end else begin
            waited++;
        end
    end
    if (!seen) begin
        if (!lineDead) begin
            $display("%s: no start bit seen within %0d cycles", curTest, START_TIMEOUT);
            errorCount++;
        end
        // later receives return at once since nothing more will arrive
        lineDead = 1'b1;
    end else begin
        // first low sample is half a cycle into the start bit
        repeat (`CONSOLE_CLKS_PER_BIT / 2 - 1) @(negedge CLK);
        if (txd !== 1'b0) begin
            $display("%s: start bit did not last to mid-bit", curTest);
            errorCount++;
        end
        for (i = 0; i < 8; i++) begin
            repeat (`CONSOLE_CLKS_PER_BIT) @(negedge CLK);
            ch[i] = txd;
        end
        repeat (`CONSOLE_CLKS_PER_BIT) @(negedge CLK);
        if (txd !== 1'b1) begin
            $display("%s: stop bit was low", curTest);
            errorCount++;
        end
        // rest of the stop bit plus the idle cycle until txReady is back
        repeat (`CONSOLE_CLKS_PER_BIT / 2 + 2) @(negedge CLK);
    end
endtask

task automatic compareChar(input asciiChar_t expected, input asciiChar_t actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("ERROR %s: expected 0x%02h, got 0x%02h", curTest, expected, actual);
    end
endtask

task automatic expectChar(input asciiChar_t expected);
    asciiChar_t got;
    receiveChar(got);
    if (!lineDead) begin
        compareChar(expected, got);
    end
endtask

// length comes from the queue itself
task automatic compareText(input charQueue_t expected);
    int i;
    for (i = 0; i < expected.size(); i++) begin
        expectChar(expected[i]);
    end
endtask

function automatic asciiChar_t opKey(input calcOp_t op);
    case (op)
        OP_ADD:  return "+";
        OP_SUB:  return "-";
        OP_XOR:  return "^";
        default: return "*";
    endcase
endfunction

// digit 0 plus the 8-bit wrapped value of (a op b)
function automatic asciiChar_t calcResult(input digit_t a, input asciiChar_t opChar,
                                          input digit_t b);
    int va;
    int vb;
    int r;
    va = int'(a);
    vb = int'(b);
    case (opChar)
        "+":     r = va + vb;
        "-":     r = va - vb;
        "^":     r = va ^ vb;
        default: r = va * vb;
    endcase
    return asciiChar_t'(48 + r);
endfunction

`endif

//--- tb_consoleTop.sv
`default_nettype none

`include "console_settings.svh"

module tb_consoleTop import consoleTextPkg::*, calcPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int START_TIMEOUT = 40 * `CONSOLE_CLKS_PER_BIT;
    localparam asciiChar_t DIGIT_ZERO = "0";

    logic       CLK;
    logic       reset;
    logic       keyValid;
    asciiChar_t keyData;
    logic       txd;

    int    errorCount;
    int    checkCount;
    int    testCount;
    int    testErrorsAtStart;
    bit    lineDead;
    string curTest;

    consoleTop DUT (
        .CLK      (CLK),
        .reset    (reset),
        .keyValid (keyValid),
        .keyData  (keyData),
        .txd      (txd)
    );

    always #20 CLK = ~CLK;

    `include "tb_consoleTasks.svh"

    task automatic beginTest(input string name);
        curTest           = name;
        testErrorsAtStart = errorCount;
        testCount++;
    endtask

    task automatic endTest();
        if (errorCount == testErrorsAtStart) begin
            $display("test %0d %s: ok", testCount, curTest);
        end else begin
            $display("test %0d %s: failed with %0d errors", testCount, curTest,
                     errorCount - testErrorsAtStart);
        end
    endtask

    task automatic enterCalc();
        sendKey(KEY_MODE_CALC);
        expectChar(KEY_MODE_CALC);
        sendKey(KEY_ENTER);
        expectChar(KEY_ENTER);
        compareText(lineText("ALU:"));
    endtask

    // one calculation from first digit to the prompt that follows
    task automatic runCalc(input digit_t a, input asciiChar_t opChar, input digit_t b,
                           input bit withIgnored);
        asciiChar_t digitA;
        asciiChar_t digitB;
        digitA = DIGIT_ZERO + asciiChar_t'(a);
        digitB = DIGIT_ZERO + asciiChar_t'(b);
        if (withIgnored) begin
            sendKey("q");
        end
        sendKey(digitA);
        expectChar(digitA);
        if (withIgnored) begin
            sendKey("7");
        end
        sendKey(opChar);
        expectChar(opChar);
        sendKey(digitB);
        expectChar(digitB);
        sendKey(KEY_ENTER);
        expectChar(calcResult(a, opChar, b));
        expectChar(KEY_LINEFEED);
        compareText(lineText("MODE?"));
    endtask

    task automatic testResetOutput();
        beginTest("reset output");
        compareText(lineText("CALC READY"));
        compareText(lineText("MODE?"));
        endTest();
    endtask

    task automatic testUnknownMode();
        beginTest("unknown mode");
        sendKey("x");
        expectChar("x");
        sendKey(KEY_ENTER);
        expectChar(KEY_ENTER);
        compareText(lineText("MODE?"));
        endTest();
    endtask

    task automatic testEnterCalc();
        beginTest("enter calculator");
        enterCalc();
        endTest();
    endtask

    task automatic testCalculation();
        int     k;
        digit_t a;
        digit_t b;
        beginTest("calculation");
        for (k = 0; k < 4; k++) begin
            // the previous test left the calculator open
            if (k > 0) begin
                enterCalc();
            end
            a = digit_t'($urandom % 10);
            b = digit_t'($urandom % 10);
            runCalc(a, opKey(calcOp_t'(k)), b, 1'b0);
        end
        endTest();
    endtask

    task automatic testIgnoredKeys();
        digit_t a;
        digit_t b;
        beginTest("ignored keys");
        enterCalc();
        a = digit_t'($urandom % 10);
        b = digit_t'($urandom % 10);
        runCalc(a, "-", b, 1'b1);
        endTest();
    endtask

    initial begin
        CLK        = 1'b0;
        reset      = 1'b1;
        keyValid   = 1'b0;
        keyData    = 8'h00;
        errorCount = 0;
        checkCount = 0;
        testCount  = 0;
        lineDead   = 1'b0;
        curTest    = "setup";
        void'($urandom(32'hdef8_f9d0));
        repeat (4) @(posedge CLK);
        #2;
        reset = 1'b0;

        testResetOutput();
        testUnknownMode();
        testEnterCalc();
        testCalculation();
        testIgnoredKeys();

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
consoleTextPkg.sv
calcPkg.sv
messagePrinter.sv
keyHandler.sv
consoleTx.sv
consoleTop.sv
tb_consoleTop.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_consoleTop -f filelist.f -o simConsole &&
    simOut=$(./obj_dir/simConsole) &&
    printf '%s\n' "$simOut" &&
    printf '%s\n' "$simOut" | grep -q -F '*** PASSED ***' &&
    echo "run.sh: simulation passed" ||
    { echo "run.sh: simulation did not pass"; exit 1; }
